//--- verilog/tetris_pkg.sv
package tetris_pkg;

    // Board size in cells
    localparam int board_wide = 10;
    localparam int board_high = 20;

    // Flat cell index, row times board_wide plus column
    typedef logic [7:0] cell_t;
    typedef logic [3:0] pos_x_t;
    typedef logic [4:0] pos_y_t;
    // Rotation counted in quarter turns
    typedef logic [1:0] rot_t;
    typedef logic [2:0] size_t;
    typedef logic [9:0] row_bits_t;
    typedef logic [3:0] bcd_t;
    // Four BCD digits, ones digit in the low nibble
    typedef logic [15:0] score_t;

    // Shape table entry laid out as {height, width, c3, c2, c1, c0}
    // Each cell nibble is {dy, dx} inside the 4 by 4 box
    typedef logic [21:0] shape_entry_t;

    typedef enum logic [2:0] {
        p_empty,
        p_i,
        p_o,
        p_t,
        p_s,
        p_z,
        p_j,
        p_l
    } piece_t;

    typedef enum logic [2:0] {
        cmd_start,
        cmd_left,
        cmd_right,
        cmd_rotate,
        cmd_down
    } cmd_t;

    typedef enum logic [2:0] {
        st_idle,
        st_play,
        st_land,
        st_clear,
        st_spawn,
        st_over
    } ctrl_state_t;

    // Column where a new piece appears
    localparam pos_x_t spawn_x = 4'd4;

    // Indexed by piece, then by rotation
    // Every rotation is packed against the top left corner of its box
    localparam shape_entry_t shape_table [8][4] = '{
        '{22'h0, 22'h0, 22'h0, 22'h0},
        '{{3'd1, 3'd4, 16'h3210}, {3'd4, 3'd1, 16'hC840},
          {3'd1, 3'd4, 16'h3210}, {3'd4, 3'd1, 16'hC840}},
        '{{3'd2, 3'd2, 16'h5410}, {3'd2, 3'd2, 16'h5410},
          {3'd2, 3'd2, 16'h5410}, {3'd2, 3'd2, 16'h5410}},
        '{{3'd2, 3'd3, 16'h5210}, {3'd3, 3'd2, 16'h9541},
          {3'd2, 3'd3, 16'h6541}, {3'd3, 3'd2, 16'h8540}},
        '{{3'd2, 3'd3, 16'h5421}, {3'd3, 3'd2, 16'h9540},
          {3'd2, 3'd3, 16'h5421}, {3'd3, 3'd2, 16'h9540}},
        '{{3'd2, 3'd3, 16'h6510}, {3'd3, 3'd2, 16'h8541},
          {3'd2, 3'd3, 16'h6510}, {3'd3, 3'd2, 16'h8541}},
        '{{3'd2, 3'd3, 16'h6540}, {3'd3, 3'd2, 16'h8410},
          {3'd2, 3'd3, 16'h6210}, {3'd3, 3'd2, 16'h9851}},
        '{{3'd2, 3'd3, 16'h6542}, {3'd3, 3'd2, 16'h9840},
          {3'd2, 3'd3, 16'h4210}, {3'd3, 3'd2, 16'h9510}}
    };

endpackage

//--- verilog/shape_if.sv
interface shape_if;
    import tetris_pkg::*;

    // Piece placement requested by the controller
    piece_t piece;
    pos_x_t pos_x;
    pos_y_t pos_y;
    rot_t   rot;

    // Covered cells and bounding box returned by the shape lookup
    cell_t [3:0] cells;
    size_t       width;
    size_t       height;

    modport ctrl (
        output piece, pos_x, pos_y, rot,
        input  cells, width, height
    );

    modport shape (
        input  piece, pos_x, pos_y, rot,
        output cells, width, height
    );

endinterface

//--- verilog/board_if.sv
interface board_if;
    import tetris_pkg::*;

    // Cells of the candidate placement and of the falling piece
    cell_t [3:0] test_cells;
    cell_t [3:0] cur_cells;

    // Board updates requested by the controller
    logic   land_en;
    logic   shift_en;
    pos_y_t shift_row;
    logic   clear_en;

    // Status answered by the board
    logic   test_hit;
    logic   cur_hit;
    logic   full_found;
    pos_y_t full_row;

    modport ctrl (
        output test_cells, cur_cells, land_en, shift_en, shift_row, clear_en,
        input  test_hit, cur_hit, full_found, full_row
    );

    modport board (
        input  test_cells, cur_cells, land_en, shift_en, shift_row, clear_en,
        output test_hit, cur_hit, full_found, full_row
    );

endinterface

//--- verilog/piece_shape.sv
module piece_shape (
    shape_if.shape shp
);
    import tetris_pkg::*;

    shape_entry_t entry;
    cell_t        base;

    // Table lookup by piece type and quarter turn
    assign entry = shape_table[shp.piece][shp.rot];

    // Flat index of the top left corner of the 4 by 4 box
    assign base = cell_t'(int'(shp.pos_y) * board_wide + int'(shp.pos_x));

    // Bounding box sits above the four cell nibbles
    assign shp.width  = entry[18:16];
    assign shp.height = entry[21:19];

    always_comb begin
        logic [3:0] off;
        off = '0;
        for (int k = 0; k < 4; k++) begin
            off = entry[4*k +: 4];
            // Upper two bits step whole rows, lower two step columns
            shp.cells[k] = cell_t'(int'(base) + int'(off[3:2]) * board_wide
                                   + int'(off[1:0]));
        end
    end

endmodule

//--- verilog/board_map.sv
module board_map (
    input  logic                  clk,
    input  logic                  rst_n,
    board_if.board                brd,
    input  tetris_pkg::pos_y_t    row_sel,
    output tetris_pkg::row_bits_t row_bits
);
    import tetris_pkg::*;

    localparam int board_cells = board_wide * board_high;

    // One bit per fallen cell, row 0 at the top of the board
    logic [board_cells-1:0] fallen;

    // Hit tests for both cell sets
    // Indices past the last row read as empty since the bound checks reject them anyway
    always_comb begin
        brd.test_hit = 1'b0;
        brd.cur_hit  = 1'b0;
        for (int k = 0; k < 4; k++) begin
            if (int'(brd.test_cells[k]) < board_cells) begin
                brd.test_hit |= fallen[brd.test_cells[k]];
            end
            if (int'(brd.cur_cells[k]) < board_cells) begin
                brd.cur_hit |= fallen[brd.cur_cells[k]];
            end
        end
    end

    // Later rows overwrite earlier ones, so the lowest full row wins
    always_comb begin
        brd.full_found = 1'b0;
        brd.full_row   = '0;
        for (int r = 0; r < board_high; r++) begin
            if (&fallen[r*board_wide +: board_wide]) begin
                brd.full_found = 1'b1;
                brd.full_row   = pos_y_t'(r);
            end
        end
    end

    // Row readout for the outside world, rows past the bottom read as empty
    always_comb begin
        row_bits = '0;
        if (int'(row_sel) < board_high) begin
            row_bits = fallen[int'(row_sel)*board_wide +: board_wide];
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            fallen <= '0;
        end else if (brd.clear_en) begin
            fallen <= '0;
        end else if (brd.land_en) begin
            for (int k = 0; k < 4; k++) begin
                fallen[brd.cur_cells[k]] <= 1'b1;
            end
        end else if (brd.shift_en) begin
            // Pull the row above down into shift_row, the top row empties
            if (brd.shift_row == '0) begin
                fallen[0 +: board_wide] <= '0;
            end else begin
                fallen[int'(brd.shift_row)*board_wide +: board_wide] <=
                    fallen[(int'(brd.shift_row) - 1)*board_wide +: board_wide];
            end
        end
    end

endmodule

//--- verilog/score_counter.sv
module score_counter (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               clear,
    input  logic               incr,
    output tetris_pkg::score_t score
);
    import tetris_pkg::*;

    bcd_t [3:0] digit;
    logic [3:0] at_nine;
    // carry[k] means every digit below k is nine
    logic [4:0] carry;

    assign score = digit;

    always_comb begin
        carry[0] = 1'b1;
        for (int k = 0; k < 4; k++) begin
            at_nine[k]   = digit[k] == 4'd9;
            carry[k + 1] = carry[k] & at_nine[k];
        end
    end

    // A carry out of the top digit means 9999, which holds
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            digit <= '0;
        end else if (clear) begin
            digit <= '0;
        end else if (incr && !carry[4]) begin
            for (int k = 0; k < 4; k++) begin
                if (carry[k]) begin
                    digit[k] <= at_nine[k] ? 4'd0 : digit[k] + 4'd1;
                end
            end
        end
    end

endmodule

//--- verilog/game_ctrl.sv
module game_ctrl #(
    parameter int GRAVITY_CYCLES = 3000
) (
    input  logic               clk,
    input  logic               rst_n,
    input  tetris_pkg::cmd_t   cmd,
    input  logic               cmd_req,
    output logic               cmd_ack,
    input  tetris_pkg::piece_t next_piece,
    shape_if.ctrl              cur,
    shape_if.ctrl              tst,
    board_if.ctrl              brd,
    output logic               score_clear,
    output logic               score_incr,
    output logic               playing,
    output logic               game_over,
    output tetris_pkg::piece_t cur_piece,
    output tetris_pkg::pos_x_t piece_x,
    output tetris_pkg::pos_y_t piece_y,
    output tetris_pkg::rot_t   piece_rot
);
    import tetris_pkg::*;

    localparam int grav_w = $clog2(GRAVITY_CYCLES + 1);

    ctrl_state_t       state;
    logic              stable;
    logic              pending;
    logic              take;
    logic              do_start;
    logic              grav_fire;
    logic [grav_w-1:0] grav_cnt;
    cmd_t              act;
    logic              move_ok;
    logic              shifting;
    pos_y_t            shift_row;

    // Commands are only taken while no landing sequence is running
    assign stable    = state inside {st_idle, st_play, st_over};
    assign take      = cmd_req && !cmd_ack && !pending && stable;
    assign do_start  = take && cmd == cmd_start;
    assign grav_fire = state == st_play && !take && !pending
                       && grav_cnt == grav_w'(GRAVITY_CYCLES - 1);

    // A gravity tick behaves exactly like a down command
    assign act = take ? cmd : cmd_down;

    assign cur.piece = cur_piece;
    assign cur.pos_x = piece_x;
    assign cur.pos_y = piece_y;
    assign cur.rot   = piece_rot;

    // Candidate placement for the command being evaluated
    always_comb begin
        tst.piece = cur_piece;
        tst.pos_x = piece_x;
        tst.pos_y = piece_y;
        tst.rot   = piece_rot;
        case (act)
            cmd_left:   tst.pos_x = piece_x - 4'd1;
            cmd_right:  tst.pos_x = piece_x + 4'd1;
            cmd_rotate: tst.rot   = piece_rot + 2'd1;
            default:    tst.pos_y = piece_y + 5'd1;
        endcase
    end

    // Wall and floor rules, then the fallen-cell test on the candidate
    always_comb begin
        case (act)
            cmd_left:   move_ok = piece_x != '0;
            cmd_right:  move_ok = int'(piece_x) + int'(cur.width) < board_wide;
            cmd_rotate: move_ok = int'(piece_x) + int'(tst.width) <= board_wide
                                  && int'(piece_y) + int'(tst.height) <= board_high;
            default:    move_ok = int'(piece_y) + int'(cur.height) < board_high;
        endcase
        move_ok = move_ok && !brd.test_hit;
    end

    assign brd.test_cells = tst.cells;
    assign brd.cur_cells  = cur.cells;
    assign brd.land_en    = state == st_land;
    assign brd.shift_en   = state == st_clear && shifting;
    assign brd.shift_row  = shift_row;
    assign brd.clear_en   = do_start;

    assign score_clear = do_start;
    assign score_incr  = state == st_clear && !shifting && brd.full_found;

    assign playing   = state inside {st_play, st_land, st_clear, st_spawn};
    assign game_over = state == st_over;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= st_idle;
            cmd_ack   <= 1'b0;
            pending   <= 1'b0;
            grav_cnt  <= '0;
            shifting  <= 1'b0;
            shift_row <= '0;
            cur_piece <= p_empty;
            piece_x   <= '0;
            piece_y   <= '0;
            piece_rot <= '0;
        end else begin
            // Ack waits until the state has settled, so the result is already visible
            if (take) begin
                pending <= 1'b1;
            end else if (pending && stable) begin
                pending <= 1'b0;
                cmd_ack <= 1'b1;
            end else if (cmd_ack && !cmd_req) begin
                cmd_ack <= 1'b0;
            end

            // Gravity restarts on each taken command and whenever play is left
            if (state != st_play || take || grav_fire) begin
                grav_cnt <= '0;
            end else begin
                grav_cnt <= grav_cnt + 1'b1;
            end

            case (state)
                st_idle, st_over, st_play: begin
                    if (do_start) begin
                        cur_piece <= next_piece;
                        piece_x   <= spawn_x;
                        piece_y   <= '0;
                        piece_rot <= '0;
                        state     <= st_spawn;
                    end else if (state == st_play && (take || grav_fire)) begin
                        if (move_ok) begin
                            piece_x   <= tst.pos_x;
                            piece_y   <= tst.pos_y;
                            piece_rot <= tst.rot;
                        end else if (act == cmd_down) begin
                            state <= st_land;
                        end
                    end
                end
                st_land: begin
                    shifting <= 1'b0;
                    state    <= st_clear;
                end
                st_clear: begin
                    if (shifting) begin
                        // Walk upward one row per cycle until the top row is emptied
                        if (shift_row == '0) begin
                            shifting <= 1'b0;
                        end else begin
                            shift_row <= shift_row - 5'd1;
                        end
                    end else if (brd.full_found) begin
                        shifting  <= 1'b1;
                        shift_row <= brd.full_row;
                    end else begin
                        cur_piece <= next_piece;
                        piece_x   <= spawn_x;
                        piece_y   <= '0;
                        piece_rot <= '0;
                        state     <= st_spawn;
                    end
                end
                st_spawn: begin
                    // New piece already overlaps the stack, game ends
                    state <= brd.cur_hit ? st_over : st_play;
                end
                default: begin
                    state <= st_idle;
                end
            endcase
        end
    end

endmodule

//--- verilog/tetris_core.sv
module tetris_core #(
    parameter int GRAVITY_CYCLES = 3000
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  tetris_pkg::cmd_t      cmd,
    input  logic                  cmd_req,
    output logic                  cmd_ack,
    input  tetris_pkg::piece_t    next_piece,
    output logic                  playing,
    output logic                  game_over,
    output tetris_pkg::score_t    score,
    output tetris_pkg::piece_t    cur_piece,
    output tetris_pkg::pos_x_t    piece_x,
    output tetris_pkg::pos_y_t    piece_y,
    output tetris_pkg::rot_t      piece_rot,
    input  tetris_pkg::pos_y_t    row_sel,
    output tetris_pkg::row_bits_t row_bits
);

    logic score_clear;
    logic score_incr;

    // Falling piece, candidate placement and board access
    shape_if cur_shape ();
    shape_if test_shape ();
    board_if brd_bus ();

    game_ctrl #(
        .GRAVITY_CYCLES(GRAVITY_CYCLES)
    ) i_game_ctrl (
        .clk        (clk),
        .rst_n      (rst_n),
        .cmd        (cmd),
        .cmd_req    (cmd_req),
        .cmd_ack    (cmd_ack),
        .next_piece (next_piece),
        .cur        (cur_shape.ctrl),
        .tst        (test_shape.ctrl),
        .brd        (brd_bus.ctrl),
        .score_clear(score_clear),
        .score_incr (score_incr),
        .playing    (playing),
        .game_over  (game_over),
        .cur_piece  (cur_piece),
        .piece_x    (piece_x),
        .piece_y    (piece_y),
        .piece_rot  (piece_rot)
    );

    piece_shape i_cur_shape (
        .shp(cur_shape.shape)
    );

    piece_shape i_test_shape (
        .shp(test_shape.shape)
    );

    board_map i_board_map (
        .clk     (clk),
        .rst_n   (rst_n),
        .brd     (brd_bus.board),
        .row_sel (row_sel),
        .row_bits(row_bits)
    );

    score_counter i_score_counter (
        .clk  (clk),
        .rst_n(rst_n),
        .clear(score_clear),
        .incr (score_incr),
        .score(score)
    );

endmodule

//--- bench/tetris_chk.sv
module tetris_chk (
    input logic clk,
    input logic rst_n,
    input logic cmd_req,
    input logic cmd_ack,
    input logic playing,
    input logic game_over
);
    timeunit 1ns;
    timeprecision 100ps;

    // Failure count, read by the testbench for its closing summary
    int assert_errors;

    initial begin
        assert_errors = 0;
    end

    // An ack may only answer a request that is still raised
    ack_rise_needs_req: assert property (
        @(posedge clk) disable iff (!rst_n)
        $rose(cmd_ack) |-> cmd_req
    ) else begin
        assert_errors++;
        $error("cmd_ack rose while cmd_req was low");
    end

    // The ack is only withdrawn once the request has been dropped
    ack_fall_after_req: assert property (
        @(posedge clk) disable iff (!rst_n)
        $fell(cmd_ack) |-> !$past(cmd_req)
    ) else begin
        assert_errors++;
        $error("cmd_ack fell while cmd_req was still high");
    end

    // A game is either running or finished, never both
    play_over_exclusive: assert property (
        @(posedge clk) disable iff (!rst_n)
        !(playing && game_over)
    ) else begin
        assert_errors++;
        $error("playing and game_over are both high");
    end

endmodule

bind tetris_core tetris_chk i_tetris_chk (
    .clk      (clk),
    .rst_n    (rst_n),
    .cmd_req  (cmd_req),
    .cmd_ack  (cmd_ack),
    .playing  (playing),
    .game_over(game_over)
);

//--- bench/tetris_tb.sv
module tetris_tb;
    timeunit 1ns;
    timeprecision 100ps;

    import tetris_pkg::*;

    localparam int grav_cycles = 3000;
    // Worst landing with two cleared rows takes about fifty cycles
    localparam int ack_timeout = 200;

    logic      clk;
    logic      rst_n;
    cmd_t      cmd;
    logic      cmd_req;
    logic      cmd_ack;
    piece_t    next_piece;
    logic      playing;
    logic      game_over;
    score_t    score;
    piece_t    cur_piece;
    pos_x_t    piece_x;
    pos_y_t    piece_y;
    rot_t      piece_rot;
    pos_y_t    row_sel;
    row_bits_t row_bits;

    // Reference board where bit c of entry r holds column c of row r
    row_bits_t model_rows [board_high];
    int        model_score;
    int        check_errors;
    int        timeout_errors;
    integer    seed;

    tetris_core #(
        .GRAVITY_CYCLES(grav_cycles)
    ) i_tetris_core (
        .clk       (clk),
        .rst_n     (rst_n),
        .cmd       (cmd),
        .cmd_req   (cmd_req),
        .cmd_ack   (cmd_ack),
        .next_piece(next_piece),
        .playing   (playing),
        .game_over (game_over),
        .score     (score),
        .cur_piece (cur_piece),
        .piece_x   (piece_x),
        .piece_y   (piece_y),
        .piece_rot (piece_rot),
        .row_sel   (row_sel),
        .row_bits  (row_bits)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] exp);
        check_errors++;
        $display("CHECK FAILED at %0t: %s is 'h%0h, expected 'h%0h", $time, name, got, exp);
    endtask

    task automatic report_timeout(input string what);
        timeout_errors++;
        $display("TIMEOUT at %0t: %s", $time, what);
    endtask

    // Four-phase exchange with outputs sampled on the falling edge
    task automatic send_cmd(input cmd_t c);
        int n;
        @(posedge clk);
        cmd     <= c;
        cmd_req <= 1'b1;
        n = 0;
        @(negedge clk);
        while (!cmd_ack && n < ack_timeout) begin
            @(negedge clk);
            n++;
        end
        if (!cmd_ack) begin
            report_timeout($sformatf("no cmd_ack for command %s", c.name()));
        end
        @(posedge clk);
        cmd_req <= 1'b0;
        n = 0;
        @(negedge clk);
        while (cmd_ack && n < ack_timeout) begin
            @(negedge clk);
            n++;
        end
        if (cmd_ack) begin
            report_timeout("cmd_ack stayed high after cmd_req dropped");
        end
    endtask

    task automatic model_reset();
        foreach (model_rows[r]) begin
            model_rows[r] = '0;
        end
        model_score = 0;
    endtask

    // An O covers columns x and x+1 of rows y and y+1 in every rotation
    function automatic bit model_o_fits(input int x, input int y);
        if (y + 2 > board_high) begin
            return 1'b0;
        end
        return !(model_rows[y][x] || model_rows[y][x+1]
                 || model_rows[y+1][x] || model_rows[y+1][x+1]);
    endfunction

    task automatic model_land_o(input int x, input int y);
        bit full;
        int row;
        model_rows[y][x]     = 1'b1;
        model_rows[y][x+1]   = 1'b1;
        model_rows[y+1][x]   = 1'b1;
        model_rows[y+1][x+1] = 1'b1;
        full = 1'b1;
        while (full) begin
            full = 1'b0;
            row  = 0;
            for (int r = 0; r < board_high; r++) begin
                if (&model_rows[r]) begin
                    full = 1'b1;
                    row  = r;
                end
            end
            // Lowest full row goes first and everything above drops by one
            if (full) begin
                for (int r = row; r > 0; r--) begin
                    model_rows[r] = model_rows[r-1];
                end
                model_rows[0] = '0;
                if (model_score < 9999) begin
                    model_score++;
                end
            end
        end
    endtask

    function automatic score_t to_bcd(input int v);
        score_t s;
        for (int k = 0; k < 4; k++) begin
            s[4*k +: 4] = bcd_t'(v % 10);
            v = v / 10;
        end
        return s;
    endfunction

    // Walks row_sel over the board while row_bits follows in the same cycle
    task automatic compare_board();
        for (int r = 0; r < board_high; r++) begin
            @(posedge clk);
            row_sel <= pos_y_t'(r);
            @(negedge clk);
            if (row_bits !== model_rows[r]) begin
                report_mismatch($sformatf("row_bits of row %0d", r), row_bits, model_rows[r]);
            end
        end
        if (score !== to_bcd(model_score)) begin
            report_mismatch("score", score, to_bcd(model_score));
        end
    endtask

    task automatic start_game(input piece_t p);
        @(posedge clk);
        next_piece <= p;
        send_cmd(cmd_start);
        model_reset();
    endtask

    // Steers a freshly spawned O to column x and drops it onto the stack
    task automatic place_o(input int x);
        int y;
        for (int k = x; k < 4; k++) begin
            send_cmd(cmd_left);
        end
        for (int k = 4; k < x; k++) begin
            send_cmd(cmd_right);
        end
        if (piece_x !== pos_x_t'(x)) begin
            report_mismatch("piece_x", piece_x, x);
        end
        y = 0;
        while (model_o_fits(x, y + 1)) begin
            y++;
        end
        repeat (y) send_cmd(cmd_down);
        if (piece_y !== pos_y_t'(y)) begin
            report_mismatch("piece_y", piece_y, y);
        end
        // No room below, so this down lands the piece
        send_cmd(cmd_down);
        model_land_o(x, y);
    endtask

    task automatic test_reset_state();
        if (cmd_ack !== 1'b0) report_mismatch("cmd_ack", cmd_ack, 0);
        if (playing !== 1'b0) report_mismatch("playing", playing, 0);
        if (game_over !== 1'b0) report_mismatch("game_over", game_over, 0);
        if (cur_piece !== p_empty) report_mismatch("cur_piece", cur_piece, p_empty);
        compare_board();
    endtask

    task automatic test_start();
        start_game(p_t);
        if (playing !== 1'b1) report_mismatch("playing", playing, 1);
        if (piece_x !== 4'd4) report_mismatch("piece_x", piece_x, 4);
        if (piece_y !== 5'd0) report_mismatch("piece_y", piece_y, 0);
        if (piece_rot !== 2'd0) report_mismatch("piece_rot", piece_rot, 0);
        if (cur_piece !== p_t) report_mismatch("cur_piece", cur_piece, p_t);
        compare_board();
    endtask

    task automatic test_walls();
        start_game(p_o);
        repeat (6) send_cmd(cmd_left);
        if (piece_x !== 4'd0) report_mismatch("piece_x", piece_x, 0);
        // Width two stops the O at column 8
        repeat (10) send_cmd(cmd_right);
        if (piece_x !== 4'd8) report_mismatch("piece_x", piece_x, 8);
        start_game(p_i);
        send_cmd(cmd_rotate);
        if (piece_rot !== 2'd1) report_mismatch("piece_rot", piece_rot, 1);
        repeat (3) send_cmd(cmd_right);
        if (piece_x !== 4'd7) report_mismatch("piece_x", piece_x, 7);
        // Lying flat would need columns 7 to 10
        send_cmd(cmd_rotate);
        if (piece_rot !== 2'd1) report_mismatch("piece_rot", piece_rot, 1);
        if (piece_x !== 4'd7) report_mismatch("piece_x", piece_x, 7);
    endtask

    task automatic test_landing();
        start_game(p_o);
        place_o(0);
        if (piece_x !== 4'd4) report_mismatch("piece_x", piece_x, 4);
        if (piece_y !== 5'd0) report_mismatch("piece_y", piece_y, 0);
        if (cur_piece !== p_o) report_mismatch("cur_piece", cur_piece, p_o);
        if (playing !== 1'b1) report_mismatch("playing", playing, 1);
        compare_board();
    endtask

    task automatic test_row_clear();
        int xs [5];
        int j;
        int t;
        start_game(p_o);
        for (int k = 0; k < 5; k++) begin
            xs[k] = 2 * k;
        end
        // Shuffle the five columns
        for (int k = 4; k > 0; k--) begin
            j     = $unsigned($random(seed)) % (k + 1);
            t     = xs[k];
            xs[k] = xs[j];
            xs[j] = t;
        end
        for (int k = 0; k < 5; k++) begin
            place_o(xs[k]);
        end
        compare_board();
        if (score !== 16'h0002) report_mismatch("score", score, 16'h0002);
    endtask

    task automatic test_gravity();
        int n;
        start_game(p_o);
        n = 0;
        while (piece_y === 5'd0 && n < grav_cycles + 20) begin
            @(negedge clk);
            n++;
        end
        if (piece_y === 5'd0) begin
            report_timeout("piece did not fall without a command");
        end else if (piece_y !== 5'd1) begin
            report_mismatch("piece_y", piece_y, 1);
        end
    endtask

    task automatic test_game_over();
        bit exp_over;
        int n;
        start_game(p_o);
        exp_over = 1'b0;
        n = 0;
        while (!exp_over && n < board_high) begin
            place_o(4);
            // The next O spawns over columns 4 and 5 of rows 0 and 1
            exp_over = !model_o_fits(4, 0);
            if (game_over !== exp_over) report_mismatch("game_over", game_over, exp_over);
            if (playing !== !exp_over) report_mismatch("playing", playing, !exp_over);
            n++;
        end
        // A move is still acknowledged once the game is over
        send_cmd(cmd_left);
        compare_board();
        start_game(p_o);
        if (playing !== 1'b1) report_mismatch("playing", playing, 1);
        if (game_over !== 1'b0) report_mismatch("game_over", game_over, 0);
        compare_board();
    endtask

    initial begin
        $timeformat(-9, 1, " ns", 0);
        seed           = 32'h04ce_ed3f;
        check_errors   = 0;
        timeout_errors = 0;
        rst_n          = 1'b0;
        cmd            = cmd_start;
        cmd_req        = 1'b0;
        next_piece     = p_o;
        row_sel        = '0;
        model_reset();
        repeat (10) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);

        test_reset_state();
        test_start();
        test_walls();
        test_landing();
        test_row_clear();
        test_gravity();
        test_game_over();

        $display("Summary: %0d check errors, %0d timeouts, %0d assertion failures",
                 check_errors, timeout_errors, i_tetris_core.i_tetris_chk.assert_errors);
        if (check_errors == 0 && timeout_errors == 0
            && i_tetris_core.i_tetris_chk.assert_errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

//--- tetris.f
verilog/tetris_pkg.sv
verilog/shape_if.sv
verilog/board_if.sv
verilog/piece_shape.sv
verilog/board_map.sv
verilog/score_counter.sv
verilog/game_ctrl.sv
verilog/tetris_core.sv
bench/tetris_chk.sv
bench/tetris_tb.sv
